// ==== hdl/fetch_pkg.sv ====
package fetch_pkg;

    ////////////////////
    // widths with a meaning

    // instruction address
    typedef logic [31:0] addr_t;

    // instruction or data word
    typedef logic [31:0] word_t;

    // architectural register index
    typedef logic [4:0] reg_idx_t;

    // operand source for the fetch-stage compare and jalr base
    typedef enum logic [1:0] {
        FWD_RF     = 2'd0,
        FWD_EX_MEM = 2'd1,
        FWD_MEM_WB = 2'd2
    } fwd_sel_t;

    ////////////////////
    // rv32i encodings

    // control-flow opcodes
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // addi x0, x0, 0
    localparam word_t NOP_INSTR = 32'h0000_0013;

endpackage

// ==== hdl/fetch_decode.sv ====
`timescale 1ns/100ps

module fetch_decode (
    input  fetch_pkg::word_t    instr_i,

    output logic                is_jal_o,
    output logic                is_jalr_o,
    output logic                is_branch_o,
    output logic [2:0]          funct3_o,
    output fetch_pkg::reg_idx_t rs1_o,
    output fetch_pkg::reg_idx_t rs2_o,
    output fetch_pkg::reg_idx_t rd_o,
    output fetch_pkg::word_t    imm_o
);
    import fetch_pkg::*;

    logic [6:0] opcode;
    word_t      imm_i_type;
    word_t      imm_b_type;
    word_t      imm_j_type;

    assign opcode = instr_i[6:0];

    assign is_jal_o    = (opcode == OPC_JAL);
    assign is_jalr_o   = (opcode == OPC_JALR);
    assign is_branch_o = (opcode == OPC_BRANCH);

    // branch kind travels in funct3
    assign funct3_o = instr_i[14:12];

    ////////////////////
    // immediates, all sign-extended

    assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};

    assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                         instr_i[30:25], instr_i[11:8], 1'b0};

    assign imm_j_type = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                         instr_i[20], instr_i[30:21], 1'b0};

    always_comb begin
        if (is_jal_o) begin
            imm_o = imm_j_type;
        end else if (is_jalr_o) begin
            imm_o = imm_i_type;
        end else if (is_branch_o) begin
            imm_o = imm_b_type;
        end else begin
            imm_o = '0;
        end
    end

    ////////////////////
    // register fields

    // zero index means no hazard downstream
    assign rs1_o = (is_jalr_o || is_branch_o) ? instr_i[19:15] : '0;
    assign rs2_o = is_branch_o ? instr_i[24:20] : '0;

    // rd only matters for the return stack
    assign rd_o = (is_jal_o || is_jalr_o) ? instr_i[11:7] : '0;

endmodule

// ==== hdl/operand_forward.sv ====
`timescale 1ns/100ps

module operand_forward (
    input  fetch_pkg::reg_idx_t rs1_i,
    input  fetch_pkg::reg_idx_t rs2_i,
    input  logic                uses_rs1_i,
    input  logic                uses_rs2_i,

    input  fetch_pkg::word_t    rs1_data_i,
    input  fetch_pkg::word_t    rs2_data_i,
    input  fetch_pkg::word_t    ex_mem_result_i,
    input  fetch_pkg::word_t    mem_wb_result_i,

    input  fetch_pkg::reg_idx_t rd_id_i,
    input  fetch_pkg::reg_idx_t rd_ex_i,
    input  fetch_pkg::reg_idx_t rd_mem_i,
    input  fetch_pkg::reg_idx_t rd_wb_i,
    input  logic                reg_write_id_i,
    input  logic                reg_write_ex_i,
    input  logic                reg_write_mem_i,
    input  logic                reg_write_wb_i,
    input  logic                mem_read_ex_i,

    output fetch_pkg::word_t    fwd_a_o,
    output fetch_pkg::word_t    fwd_b_o,
    output logic                pred_needed_o,
    output logic                stall_inner_o
);
    import fetch_pkg::*;

    fwd_sel_t sel_a;
    fwd_sel_t sel_b;
    logic     dep_id;
    logic     dep_load;

    // x0 never matches a producer
    function automatic logic src_hit(reg_idx_t rs, logic used, reg_idx_t rd, logic we);
        return used && (rs != '0) && we && (rd == rs);
    endfunction

    function automatic fwd_sel_t pick_src(reg_idx_t rs, logic used);
        if (src_hit(rs, used, rd_mem_i, reg_write_mem_i)) begin
            return FWD_EX_MEM;
        end else if (src_hit(rs, used, rd_wb_i, reg_write_wb_i)) begin
            return FWD_MEM_WB;
        end
        return FWD_RF;
    endfunction

    ////////////////////
    // forwarding muxes

    always_comb begin
        sel_a = pick_src(rs1_i, uses_rs1_i);
        sel_b = pick_src(rs2_i, uses_rs2_i);
        case (sel_a)
            FWD_EX_MEM: fwd_a_o = ex_mem_result_i;
            FWD_MEM_WB: fwd_a_o = mem_wb_result_i;
            default:    fwd_a_o = rs1_data_i;
        endcase
        case (sel_b)
            FWD_EX_MEM: fwd_b_o = ex_mem_result_i;
            FWD_MEM_WB: fwd_b_o = mem_wb_result_i;
            default:    fwd_b_o = rs2_data_i;
        endcase
    end

    ////////////////////
    // unresolvable operands

    // producer still in decode, value not known yet
    assign dep_id = src_hit(rs1_i, uses_rs1_i, rd_id_i, reg_write_id_i)
                 || src_hit(rs2_i, uses_rs2_i, rd_id_i, reg_write_id_i);

    // load in execute, data arrives from memory next cycle
    assign dep_load = mem_read_ex_i
                   && (src_hit(rs1_i, uses_rs1_i, rd_ex_i, reg_write_ex_i)
                    || src_hit(rs2_i, uses_rs2_i, rd_ex_i, reg_write_ex_i));

    assign stall_inner_o = dep_load;
    assign pred_needed_o = dep_id && !dep_load;

endmodule

// ==== hdl/branch_predictor.sv ====
`timescale 1ns/100ps

module branch_predictor #(
    parameter int BHT_ENTRIES = 64,
    parameter int RAS_DEPTH   = 4
) (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                hold_i,

    input  fetch_pkg::addr_t    pc_i,
    input  fetch_pkg::addr_t    pc_plus4_i,
    input  logic                is_jal_i,
    input  logic                is_jalr_i,
    input  fetch_pkg::reg_idx_t rs1_i,
    input  fetch_pkg::reg_idx_t rd_i,

    input  logic                resolve_valid_i,
    input  fetch_pkg::addr_t    resolve_pc_i,
    input  logic                resolve_taken_i,

    output logic                pred_taken_o,
    output fetch_pkg::addr_t    ras_top_o
);
    import fetch_pkg::*;

    localparam int         IDX_W   = $clog2(BHT_ENTRIES);
    localparam int         SP_W    = (RAS_DEPTH > 1) ? $clog2(RAS_DEPTH) : 1;
    localparam int         CNT_W   = $clog2(RAS_DEPTH + 1);
    localparam logic [1:0] WEAK_NT = 2'b01;

    logic [1:0]       bht [BHT_ENTRIES];
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;

    addr_t            ras [RAS_DEPTH];
    logic [SP_W-1:0]  sp;
    logic [SP_W-1:0]  sp_inc;
    logic [SP_W-1:0]  sp_dec;
    logic [CNT_W-1:0] count;
    logic             rd_link;
    logic             rs1_link;
    logic             push;
    logic             pop;

    ////////////////////
    // 2-bit counters

    assign rd_idx = pc_i[IDX_W+1:2];
    assign wr_idx = resolve_pc_i[IDX_W+1:2];

    // msb of the counter is the prediction
    assign pred_taken_o = bht[rd_idx][1];

    // training ignores the stall
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < BHT_ENTRIES; i++) begin
                bht[i] <= WEAK_NT;
            end
        end else if (resolve_valid_i) begin
            if (resolve_taken_i && bht[wr_idx] != 2'b11) begin
                bht[wr_idx] <= bht[wr_idx] + 2'd1;
            end else if (!resolve_taken_i && bht[wr_idx] != 2'b00) begin
                bht[wr_idx] <= bht[wr_idx] - 2'd1;
            end
        end
    end

    ////////////////////
    // return-address stack

    // x1 and x5 are link registers
    assign rd_link  = (rd_i == 5'd1) || (rd_i == 5'd5);
    assign rs1_link = (rs1_i == 5'd1) || (rs1_i == 5'd5);

    assign push = (is_jal_i || is_jalr_i) && rd_link;
    assign pop  = is_jalr_i && rs1_link && !rd_link && (count != '0);

    // circular pointer, oldest entry lost on overflow
    assign sp_inc = (sp == SP_W'(RAS_DEPTH - 1)) ? '0 : sp + 1'b1;
    assign sp_dec = (sp == '0) ? SP_W'(RAS_DEPTH - 1) : sp - 1'b1;

    assign ras_top_o = (count == '0) ? '0 : ras[sp_dec];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            sp    <= '0;
            count <= '0;
        end else if (!hold_i) begin
            if (push) begin
                sp <= sp_inc;
                if (count != CNT_W'(RAS_DEPTH)) begin
                    count <= count + 1'b1;
                end
            end else if (pop) begin
                sp    <= sp_dec;
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!hold_i && push) begin
            ras[sp] <= pc_plus4_i;
        end
    end

endmodule

// ==== hdl/branch_resolve.sv ====
`timescale 1ns/100ps

module branch_resolve (
    input  fetch_pkg::addr_t pc_i,
    input  fetch_pkg::word_t imm_i,
    input  logic [2:0]       funct3_i,
    input  logic             is_jal_i,
    input  logic             is_jalr_i,
    input  logic             is_branch_i,

    input  fetch_pkg::word_t fwd_a_i,
    input  fetch_pkg::word_t fwd_b_i,

    input  logic             pred_needed_i,
    input  logic             pred_taken_i,
    input  fetch_pkg::addr_t ras_top_i,

    output logic             redirect_o,
    output fetch_pkg::addr_t target_o,
    output logic             taken_o
);
    import fetch_pkg::*;

    logic  cmp_eq;
    logic  cmp_lt;
    logic  cmp_ltu;
    logic  cmp_taken;
    addr_t base;
    addr_t sum;

    ////////////////////
    // comparator

    assign cmp_eq  = (fwd_a_i == fwd_b_i);
    assign cmp_lt  = ($signed(fwd_a_i) < $signed(fwd_b_i));
    assign cmp_ltu = (fwd_a_i < fwd_b_i);

    always_comb begin
        case (funct3_i)
            3'b000:  cmp_taken = cmp_eq;
            3'b001:  cmp_taken = !cmp_eq;
            3'b100:  cmp_taken = cmp_lt;
            3'b101:  cmp_taken = !cmp_lt;
            3'b110:  cmp_taken = cmp_ltu;
            3'b111:  cmp_taken = !cmp_ltu;
            default: cmp_taken = 1'b0;
        endcase
    end

    // predictor stands in when the operand is not ready
    assign taken_o = pred_needed_i ? pred_taken_i : cmp_taken;

    ////////////////////
    // target

    // jalr base from the stack if rs1 still in flight
    assign base = is_jalr_i ? (pred_needed_i ? ras_top_i : fwd_a_i) : pc_i;
    assign sum  = base + imm_i;

    assign target_o = is_jalr_i ? {sum[31:1], 1'b0} : sum;

    assign redirect_o = is_jal_i || is_jalr_i || (is_branch_i && taken_o);

endmodule

// ==== hdl/pc_gen.sv ====
`timescale 1ns/100ps

module pc_gen #(
    parameter fetch_pkg::addr_t RESET_PC = '0
) (
    input  logic             clk_i,
    input  logic             rst_n_i,

    input  logic             stall_i,
    input  logic             stall_inner_i,
    input  logic             flush_i,
    input  fetch_pkg::addr_t rollback_pc_i,
    input  logic             redirect_i,
    input  fetch_pkg::addr_t target_i,

    input  fetch_pkg::word_t instr_i,

    output fetch_pkg::addr_t pc_o,
    output fetch_pkg::addr_t pc_plus4_o,
    output fetch_pkg::word_t instr_o
);
    import fetch_pkg::*;

    addr_t pc_q;
    addr_t pc_next;

    assign pc_plus4_o = pc_q + 32'd4;

    // flush, then stall, then redirect, then sequential
    always_comb begin
        if (flush_i) begin
            pc_next = rollback_pc_i;
        end else if (stall_i || stall_inner_i) begin
            pc_next = pc_q;
        end else if (redirect_i) begin
            pc_next = target_i;
        end else begin
            pc_next = pc_plus4_o;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    assign pc_o = pc_q;

    // bubble while waiting on a load
    assign instr_o = stall_inner_i ? NOP_INSTR : instr_i;

endmodule

// ==== hdl/if_stage.sv ====
`timescale 1ns/100ps

module if_stage #(
    parameter fetch_pkg::addr_t RESET_PC    = '0,
    parameter int               BHT_ENTRIES = 64,
    parameter int               RAS_DEPTH   = 4
) (
    input  logic                clk_i,
    input  logic                rst_n_i,

    output fetch_pkg::addr_t    rom_addr_o,
    input  fetch_pkg::word_t    instr_i,
    output fetch_pkg::word_t    instr_o,
    output fetch_pkg::addr_t    pc_o,
    output logic                pred_taken_o,

    output fetch_pkg::reg_idx_t rs1_idx_o,
    output fetch_pkg::reg_idx_t rs2_idx_o,
    input  fetch_pkg::word_t    rs1_data_i,
    input  fetch_pkg::word_t    rs2_data_i,

    input  fetch_pkg::word_t    ex_mem_result_i,
    input  fetch_pkg::word_t    mem_wb_result_i,

    input  fetch_pkg::reg_idx_t rd_id_i,
    input  fetch_pkg::reg_idx_t rd_ex_i,
    input  fetch_pkg::reg_idx_t rd_mem_i,
    input  fetch_pkg::reg_idx_t rd_wb_i,
    input  logic                reg_write_id_i,
    input  logic                reg_write_ex_i,
    input  logic                reg_write_mem_i,
    input  logic                reg_write_wb_i,
    input  logic                mem_read_ex_i,

    input  logic                stall_i,
    input  logic                flush_i,
    input  fetch_pkg::addr_t    rollback_pc_i,

    input  logic                resolve_valid_i,
    input  fetch_pkg::addr_t    resolve_pc_i,
    input  logic                resolve_taken_i
);
    import fetch_pkg::*;

    logic     is_jal;
    logic     is_jalr;
    logic     is_branch;
    logic [2:0] funct3;
    reg_idx_t rd;
    word_t    imm;

    word_t    fwd_a_data;
    word_t    fwd_b_data;
    logic     pred_needed;
    logic     stall_inner;

    logic     pred_taken;
    addr_t    ras_top;

    logic     redirect;
    addr_t    target;
    logic     taken;

    addr_t    pc;
    addr_t    pc_plus4;

    assign rom_addr_o   = pc;
    assign pc_o         = pc;
    assign pred_taken_o = taken && is_branch;

    ////////////////////
    // decode and operands

    fetch_decode u_decode (
        .instr_i     (instr_i),
        .is_jal_o    (is_jal),
        .is_jalr_o   (is_jalr),
        .is_branch_o (is_branch),
        .funct3_o    (funct3),
        .rs1_o       (rs1_idx_o),
        .rs2_o       (rs2_idx_o),
        .rd_o        (rd),
        .imm_o       (imm)
    );

    operand_forward u_forward (
        .rs1_i           (rs1_idx_o),
        .rs2_i           (rs2_idx_o),
        .uses_rs1_i      (is_jalr || is_branch),
        .uses_rs2_i      (is_branch),
        .rs1_data_i      (rs1_data_i),
        .rs2_data_i      (rs2_data_i),
        .ex_mem_result_i (ex_mem_result_i),
        .mem_wb_result_i (mem_wb_result_i),
        .rd_id_i         (rd_id_i),
        .rd_ex_i         (rd_ex_i),
        .rd_mem_i        (rd_mem_i),
        .rd_wb_i         (rd_wb_i),
        .reg_write_id_i  (reg_write_id_i),
        .reg_write_ex_i  (reg_write_ex_i),
        .reg_write_mem_i (reg_write_mem_i),
        .reg_write_wb_i  (reg_write_wb_i),
        .mem_read_ex_i   (mem_read_ex_i),
        .fwd_a_o         (fwd_a_data),
        .fwd_b_o         (fwd_b_data),
        .pred_needed_o   (pred_needed),
        .stall_inner_o   (stall_inner)
    );

    ////////////////////
    // prediction and resolution

    branch_predictor #(
        .BHT_ENTRIES (BHT_ENTRIES),
        .RAS_DEPTH   (RAS_DEPTH)
    ) u_predictor (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .hold_i          (stall_i || stall_inner),
        .pc_i            (pc),
        .pc_plus4_i      (pc_plus4),
        .is_jal_i        (is_jal),
        .is_jalr_i       (is_jalr),
        .rs1_i           (rs1_idx_o),
        .rd_i            (rd),
        .resolve_valid_i (resolve_valid_i),
        .resolve_pc_i    (resolve_pc_i),
        .resolve_taken_i (resolve_taken_i),
        .pred_taken_o    (pred_taken),
        .ras_top_o       (ras_top)
    );

    branch_resolve u_resolve (
        .pc_i          (pc),
        .imm_i         (imm),
        .funct3_i      (funct3),
        .is_jal_i      (is_jal),
        .is_jalr_i     (is_jalr),
        .is_branch_i   (is_branch),
        .fwd_a_i       (fwd_a_data),
        .fwd_b_i       (fwd_b_data),
        .pred_needed_i (pred_needed),
        .pred_taken_i  (pred_taken),
        .ras_top_i     (ras_top),
        .redirect_o    (redirect),
        .target_o      (target),
        .taken_o       (taken)
    );

    ////////////////////
    // pc register

    pc_gen #(
        .RESET_PC (RESET_PC)
    ) u_pc_gen (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .stall_i       (stall_i),
        .stall_inner_i (stall_inner),
        .flush_i       (flush_i),
        .rollback_pc_i (rollback_pc_i),
        .redirect_i    (redirect),
        .target_i      (target),
        .instr_i       (instr_i),
        .pc_o          (pc),
        .pc_plus4_o    (pc_plus4),
        .instr_o       (instr_o)
    );

endmodule

// ==== dv/if_stage_props.sv ====
`timescale 1ns/100ps

module if_stage_props #(
    parameter fetch_pkg::addr_t RESET_PC = '0
) (
    input logic             clk_i,
    input logic             rst_n_i,
    input fetch_pkg::addr_t pc_i,
    input logic             flush_i,
    input fetch_pkg::addr_t rollback_pc_i,
    input logic             stall_i,
    input logic             stall_inner_i
);
    import fetch_pkg::*;

    reset_pc: assert property (@(posedge clk_i) !rst_n_i |=> (pc_i == RESET_PC))
        else $error("pc not at reset address after reset");

    flush_load: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        flush_i |=> (pc_i == $past(rollback_pc_i)))
        else $error("flush did not load the rollback pc");

    // load bubble is a single cycle
    single_bubble: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        stall_inner_i |=> (!stall_inner_i || stall_i))
        else $error("internal stall held for two cycles");

endmodule

bind if_stage if_stage_props #(
    .RESET_PC (RESET_PC)
) u_props (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .pc_i          (pc),
    .flush_i       (flush_i),
    .rollback_pc_i (rollback_pc_i),
    .stall_i       (stall_i),
    .stall_inner_i (stall_inner)
);

// ==== dv/if_stage_tb.sv ====
`timescale 1ns/100ps

module if_stage_tb;
    import fetch_pkg::*;

    localparam addr_t       START_PC     = 32'h0000_1000;
    localparam int          RESET_CYCLES = 16;
    localparam int          MAX_ROWS     = 40;

    // producer stages for the hazard field
    localparam int          ID  = 0;
    localparam int          EX  = 1;
    localparam int          MEM = 2;
    localparam int          WB  = 3;
    localparam logic [24:0] LOAD = 25'd1;

    // {stall, flush, resolve_valid, resolve_taken}
    localparam logic [3:0]  STALL   = 4'b1000;
    localparam logic [3:0]  FLUSH   = 4'b0100;
    localparam logic [3:0]  TRAIN_T = 4'b0011;

    localparam word_t       ALU_INSTR = 32'h0050_0093;
    localparam logic [12:0] BR_OFS    = 13'h040;

    // {rs1, rs2} of the branch rows
    localparam logic [9:0]  SRC_BR    = {5'd3, 5'd4};

    logic     clk_i;
    logic     rst_n_i;
    addr_t    rom_addr_o;
    word_t    instr_i;
    word_t    instr_o;
    addr_t    pc_o;
    logic     pred_taken_o;
    reg_idx_t rs1_idx_o;
    reg_idx_t rs2_idx_o;
    word_t    rs1_data_i;
    word_t    rs2_data_i;
    word_t    ex_mem_result_i;
    word_t    mem_wb_result_i;
    reg_idx_t rd_id_i;
    reg_idx_t rd_ex_i;
    reg_idx_t rd_mem_i;
    reg_idx_t rd_wb_i;
    logic     reg_write_id_i;
    logic     reg_write_ex_i;
    logic     reg_write_mem_i;
    logic     reg_write_wb_i;
    logic     mem_read_ex_i;
    logic     stall_i;
    logic     flush_i;
    addr_t    rollback_pc_i;
    logic     resolve_valid_i;
    addr_t    resolve_pc_i;
    logic     resolve_taken_i;

    ////////////////////
    // stimulus table

    string       row_name    [MAX_ROWS];
    word_t       row_instr   [MAX_ROWS];
    word_t       row_a       [MAX_ROWS];
    word_t       row_b       [MAX_ROWS];
    word_t       row_exm     [MAX_ROWS];
    word_t       row_mwb     [MAX_ROWS];
    logic [24:0] row_hz      [MAX_ROWS];
    logic [3:0]  row_fl      [MAX_ROWS];
    addr_t       row_aux     [MAX_ROWS];
    addr_t       row_exp     [MAX_ROWS];
    logic        row_exp_nop [MAX_ROWS];
    logic        row_exp_prd [MAX_ROWS];
    logic [9:0]  row_exp_src [MAX_ROWS];

    int    n_rows;
    int    n_checks;
    int    n_errors;
    int    cycles;
    int    cycle_limit;
    int    idx;
    int    errs_before;
    word_t exp_instr;

    if_stage #(
        .RESET_PC    (START_PC),
        .BHT_ENTRIES (64),
        .RAS_DEPTH   (4)
    ) uut (.*);

    always #5 clk_i = ~clk_i;

    function automatic word_t jal_word(reg_idx_t rd, logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    function automatic word_t jalr_word(reg_idx_t rd, reg_idx_t rs1, logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, OPC_JALR};
    endfunction

    function automatic word_t branch_word(logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2,
                                          logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    // one producer: rd slot plus its write enable
    function automatic logic [24:0] hazard(int stage, reg_idx_t rd);
        logic [24:0] h;
        h = '0;
        h[24 - 5*stage -: 5] = rd;
        h[4 - stage] = 1'b1;
        return h;
    endfunction

    task automatic add_row(input string name, input word_t instr, input word_t a,
                           input word_t b, input word_t exm, input word_t mwb,
                           input logic [24:0] hz, input logic [3:0] fl, input addr_t aux,
                           input addr_t exp, input logic exp_nop, input logic exp_prd,
                           input logic [9:0] exp_src);
        row_name[n_rows]    = name;
        row_instr[n_rows]   = instr;
        row_a[n_rows]       = a;
        row_b[n_rows]       = b;
        row_exm[n_rows]     = exm;
        row_mwb[n_rows]     = mwb;
        row_hz[n_rows]      = hz;
        row_fl[n_rows]      = fl;
        row_aux[n_rows]     = aux;
        row_exp[n_rows]     = exp;
        row_exp_nop[n_rows] = exp_nop;
        row_exp_prd[n_rows] = exp_prd;
        row_exp_src[n_rows] = exp_src;
        n_rows++;
    endtask

    task automatic drive_row(input int i);
        instr_i         = row_instr[i];
        rs1_data_i      = row_a[i];
        rs2_data_i      = row_b[i];
        ex_mem_result_i = row_exm[i];
        mem_wb_result_i = row_mwb[i];
        {rd_id_i, rd_ex_i, rd_mem_i, rd_wb_i, reg_write_id_i, reg_write_ex_i,
         reg_write_mem_i, reg_write_wb_i, mem_read_ex_i} = row_hz[i];
        {stall_i, flush_i, resolve_valid_i, resolve_taken_i} = row_fl[i];
        rollback_pc_i   = row_aux[i];
        resolve_pc_i    = row_aux[i];
    endtask

    task automatic fill_table();
        logic [24:0] fw;
        fw = hazard(MEM, 5'd3) | hazard(WB, 5'd4);
        // sequential and jumps
        add_row("seq0", NOP_INSTR, 0, 0, 0, 0, 0, 0, 0, 32'h1004, 0, 0, 0);
        add_row("seq1", ALU_INSTR, 0, 0, 0, 0, 0, 0, 0, 32'h1008, 0, 0, 0);
        add_row("jal", jal_word(5'd0, 21'h100), 0, 0, 0, 0, 0, 0, 0, 32'h1108, 0, 0, 0);
        add_row("jalr_rf", jalr_word(5'd0, 5'd6, 12'h004), 32'h2001, 0, 0, 0,
                0, 0, 0, 32'h2004, 0, 0, {5'd6, 5'd0});
        add_row("jalr_mem_wb", jalr_word(5'd0, 5'd7, 12'h008), 32'h3000, 0, 0, 32'h4000,
                hazard(WB, 5'd7), 0, 0, 32'h4008, 0, 0, {5'd7, 5'd0});
        add_row("jalr_ex_mem", jalr_word(5'd0, 5'd7, 12'hffc), 32'h7000, 0, 32'h5000,
                32'h6000, hazard(MEM, 5'd7) | hazard(WB, 5'd7), 0, 0, 32'h4ffc, 0, 0,
                {5'd7, 5'd0});
        add_row("jalr_x0", jalr_word(5'd0, 5'd0, 12'h010), 0, 0, 32'h8000, 32'h9000,
                hazard(MEM, 5'd0) | hazard(WB, 5'd0), 0, 0, 32'h0010, 0, 0, 0);
        // six branch kinds, operands from ex_mem and mem_wb
        add_row("beq_t", branch_word(3'b000, 5'd3, 5'd4, BR_OFS), 0, 0, 5, 5,
                fw, 0, 0, 32'h0050, 0, 1, SRC_BR);
        add_row("beq_nt", branch_word(3'b000, 5'd3, 5'd4, BR_OFS), 0, 0, 5, 6,
                fw, 0, 0, 32'h0054, 0, 0, SRC_BR);
        add_row("bne_t", branch_word(3'b001, 5'd3, 5'd4, BR_OFS), 0, 0, 1, 2,
                fw, 0, 0, 32'h0094, 0, 1, SRC_BR);
        add_row("bne_nt", branch_word(3'b001, 5'd3, 5'd4, BR_OFS), 0, 0, 7, 7,
                fw, 0, 0, 32'h0098, 0, 0, SRC_BR);
        add_row("blt_t", branch_word(3'b100, 5'd3, 5'd4, BR_OFS), 0, 0, 32'h8000_0000, 1,
                fw, 0, 0, 32'h00d8, 0, 1, SRC_BR);
        add_row("blt_nt", branch_word(3'b100, 5'd3, 5'd4, BR_OFS), 0, 0, 1, 32'hffff_ffff,
                fw, 0, 0, 32'h00dc, 0, 0, SRC_BR);
        add_row("bge_t", branch_word(3'b101, 5'd3, 5'd4, BR_OFS), 0, 0, 32'hffff_ffff,
                32'h8000_0000, fw, 0, 0, 32'h011c, 0, 1, SRC_BR);
        add_row("bge_nt", branch_word(3'b101, 5'd3, 5'd4, BR_OFS), 0, 0, 32'h8000_0000, 0,
                fw, 0, 0, 32'h0120, 0, 0, SRC_BR);
        add_row("bltu_t", branch_word(3'b110, 5'd3, 5'd4, BR_OFS), 0, 0, 1, 32'hffff_ffff,
                fw, 0, 0, 32'h0160, 0, 1, SRC_BR);
        add_row("bltu_nt", branch_word(3'b110, 5'd3, 5'd4, BR_OFS), 0, 0, 32'h8000_0000,
                32'h7fff_ffff, fw, 0, 0, 32'h0164, 0, 0, SRC_BR);
        add_row("bgeu_t", branch_word(3'b111, 5'd3, 5'd4, BR_OFS), 0, 0, 32'hffff_ffff, 0,
                fw, 0, 0, 32'h01a4, 0, 1, SRC_BR);
        add_row("bgeu_nt", branch_word(3'b111, 5'd3, 5'd4, BR_OFS), 0, 0, 0, 1,
                fw, 0, 0, 32'h01a8, 0, 0, SRC_BR);
        // load in execute, then forwarded from memory
        add_row("load_stall", branch_word(3'b000, 5'd3, 5'd4, BR_OFS), 9, 8, 0, 0,
                hazard(EX, 5'd3) | LOAD, 0, 0, 32'h01a8, 1, 0, SRC_BR);
        add_row("load_resolve", branch_word(3'b000, 5'd3, 5'd4, BR_OFS), 32'h55, 9, 9, 0,
                hazard(MEM, 5'd3), 0, 0, 32'h01e8, 0, 1, SRC_BR);
        // predictor, two strobes move weak not-taken to strong taken
        add_row("pred_untrained", branch_word(3'b001, 5'd3, 5'd4, BR_OFS), 1, 2, 0, 0,
                hazard(ID, 5'd3), 0, 0, 32'h01ec, 0, 0, SRC_BR);
        add_row("train1", ALU_INSTR, 0, 0, 0, 0, 0, STALL | TRAIN_T, 32'h01ec,
                32'h01ec, 0, 0, 0);
        add_row("train2", ALU_INSTR, 0, 0, 0, 0, 0, STALL | TRAIN_T, 32'h01ec,
                32'h01ec, 0, 0, 0);
        add_row("pred_taken", branch_word(3'b000, 5'd3, 5'd4, BR_OFS), 1, 2, 0, 0,
                hazard(ID, 5'd4), 0, 0, 32'h022c, 0, 1, SRC_BR);
        add_row("call", jal_word(5'd1, 21'h100), 0, 0, 0, 0, 0, 0, 0, 32'h032c, 0, 0, 0);
        add_row("ret", jalr_word(5'd0, 5'd1, 12'h000), 32'h9990, 0, 0, 0,
                hazard(ID, 5'd1), 0, 0, 32'h0230, 0, 0, {5'd1, 5'd0});
        // flush beats redirect, stall beats redirect
        add_row("flush_jal", jal_word(5'd0, 21'h080), 0, 0, 0, 0, 0, FLUSH, 32'h0800,
                32'h0800, 0, 0, 0);
        add_row("stall_branch", branch_word(3'b000, 5'd3, 5'd4, BR_OFS), 0, 0, 5, 5,
                fw, STALL, 0, 32'h0800, 0, 1, SRC_BR);
        add_row("seq_end", ALU_INSTR, 0, 0, 0, 0, 0, 0, 0, 32'h0804, 0, 0, 0);
    endtask

    ////////////////////
    // run limit

    always @(posedge clk_i) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        clk_i    = 1'b0;
        rst_n_i  = 1'b0;
        n_rows   = 0;
        n_checks = 0;
        n_errors = 0;
        cycles   = 0;
        instr_i         = NOP_INSTR;
        rs1_data_i      = '0;
        rs2_data_i      = '0;
        ex_mem_result_i = '0;
        mem_wb_result_i = '0;
        {rd_id_i, rd_ex_i, rd_mem_i, rd_wb_i} = '0;
        {reg_write_id_i, reg_write_ex_i, reg_write_mem_i, reg_write_wb_i} = '0;
        mem_read_ex_i   = 1'b0;
        {stall_i, flush_i, resolve_valid_i, resolve_taken_i} = '0;
        rollback_pc_i   = '0;
        resolve_pc_i    = '0;
        fill_table();
        cycle_limit = 2 * n_rows + RESET_CYCLES;

        repeat (RESET_CYCLES) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        n_checks++;
        if (rom_addr_o !== START_PC) begin
            n_errors++;
            $display("[ERROR] reset: expected %h, actual %h", START_PC, rom_addr_o);
        end

        for (idx = 0; idx < n_rows; idx++) begin
            errs_before = n_errors;
            drive_row(idx);
            exp_instr = row_exp_nop[idx] ? NOP_INSTR : row_instr[idx];
            #4;
            n_checks += 5;
            if (instr_o !== exp_instr) begin
                n_errors++;
                $display("[ERROR] %s instr_o: expected %h, actual %h",
                         row_name[idx], exp_instr, instr_o);
            end
            if (pred_taken_o !== row_exp_prd[idx]) begin
                n_errors++;
                $display("[ERROR] %s pred_taken_o: expected %b, actual %b",
                         row_name[idx], row_exp_prd[idx], pred_taken_o);
            end
            if ({rs1_idx_o, rs2_idx_o} !== row_exp_src[idx]) begin
                n_errors++;
                $display("[ERROR] %s rs1/rs2 index: expected %0d/%0d, actual %0d/%0d",
                         row_name[idx], row_exp_src[idx][9:5], row_exp_src[idx][4:0],
                         rs1_idx_o, rs2_idx_o);
            end
            @(posedge clk_i);
            #1;
            if (rom_addr_o !== row_exp[idx]) begin
                n_errors++;
                $display("[ERROR] %s rom_addr_o: expected %h, actual %h",
                         row_name[idx], row_exp[idx], rom_addr_o);
            end
            if (pc_o !== row_exp[idx]) begin
                n_errors++;
                $display("[ERROR] %s pc_o: expected %h, actual %h",
                         row_name[idx], row_exp[idx], pc_o);
            end
            $display("%-16s %s", row_name[idx], (n_errors == errs_before) ? "pass" : "fail");
        end

        $display("rows %0d, checks %0d, errors %0d", n_rows, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== src.f ====
hdl/fetch_pkg.sv
hdl/fetch_decode.sv
hdl/operand_forward.sv
hdl/branch_predictor.sv
hdl/branch_resolve.sv
hdl/pc_gen.sv
hdl/if_stage.sv
dv/if_stage_props.sv
dv/if_stage_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the fetch stage testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module if_stage_tb \
    --Mdir obj_dir -o if_stage_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/if_stage_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST OK" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
